/* Makefile */
# Verilator build and run for the waveform buffer testbench

VERILATOR ?= verilator
TOP       ?= waveform_buffer_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG := Testbench failed
PASS_MSG := Testbench passed
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/pipe_loader.sv */
`timescale 1ns/1ps

module pipe_loader
  import wave_mem_pkg::*, wave_stream_pkg::*;
(
  input  logic                 pipe_clk,
  input  logic                 reset,

  // host pipe
  input  pipe_cmd_t            pipe_in,
  input  logic                 pipe_rewind,
  output logic [15:0]          pipe_out_data,

  // memory pipe port
  output mem_wr_t              mem_wr,
  output half_addr_t           rd_half_addr,
  input  logic [15:0]          rd_half_data,

  // to player
  output logic [WORD_ADDR_W:0] loaded_words
);

  //////////////////////////////////////////////////
  // shared halfword pointer
  //////////////////////////////////////////////////

  half_addr_t ptr;  // one pointer for both write and read-back

  always_ff @(posedge pipe_clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (pipe_rewind) begin
      ptr <= '0;  // rewind beats any strobe
    end else if (pipe_in.wr_stb || pipe_in.rd_stb) begin
      ptr <= ptr + 1'b1;  // wraps at 2048 halfwords
    end
  end

  //////////////////////////////////////////////////
  // write request, same cycle as the strobe
  //////////////////////////////////////////////////

  always_comb begin
    mem_wr.addr = ptr;
    mem_wr.data = pipe_in.data;
    mem_wr.en   = pipe_in.wr_stb;
  end

  // read-back: memory registers the halfword at ptr every edge,
  // so the old pointer's data shows up one cycle after rd_stb
  assign rd_half_addr  = ptr;
  assign pipe_out_data = rd_half_data;

  //////////////////////////////////////////////////
  // loaded length, high-water mark in words
  //////////////////////////////////////////////////

  logic [WORD_ADDR_W:0] wr_words;  // words covered once this write lands
  logic [WORD_ADDR_W:0] hwm_q;

  // halfword p covers words 0..p/2, i.e. (p+1)/2 rounded up
  assign wr_words = {1'b0, ptr[HALF_ADDR_W-1:1]} + 1'b1;

  always_ff @(posedge pipe_clk) begin
    if (reset) begin
      hwm_q <= '0;
    end else if (pipe_in.wr_stb && (wr_words > hwm_q)) begin
      hwm_q <= wr_words;  // rewind leaves the mark alone
    end
  end

  assign loaded_words = hwm_q;

endmodule

/* design/wave_mem_pkg.sv */
package wave_mem_pkg;

  //////////////////////////////////////////////////
  // memory geometry
  //////////////////////////////////////////////////

  localparam int DEPTH_WORDS = 1024;  // 32-bit words in the block memory
  localparam int HALF_ADDR_W = 11;    // host side, halfword granular
  localparam int WORD_ADDR_W = 10;    // playback side, word granular

  typedef logic [HALF_ADDR_W-1:0] half_addr_t;  // bit 0 picks the lane
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;

  //////////////////////////////////////////////////
  // memory word, two views of the same 32 bits
  //////////////////////////////////////////////////

  // playback view: two signed channel samples
  typedef struct packed {
    logic signed [15:0] chan_b;  // high half, odd halfword
    logic signed [15:0] chan_a;  // low half, even halfword
  } chan_pair_t;

  // half[0] is the low lane, written at even pipe addresses
  typedef union packed {
    logic [1:0][15:0] half;  // pipe view
    chan_pair_t       chan;  // playback view
  } mem_word_u;

endpackage

/* design/wave_memory.sv */
`timescale 1ns/1ps

module wave_memory
  import wave_mem_pkg::*, wave_stream_pkg::*;
(
  input  logic        pipe_clk,

  // pipe port, 16-bit
  input  mem_wr_t     mem_wr,
  input  half_addr_t  rd_half_addr,
  output logic [15:0] rd_half_data,

  // playback port, 32-bit
  input  word_addr_t  play_addr,
  output mem_word_u   play_data
);

  // inferred dual-port block memory
  mem_word_u mem [DEPTH_WORDS];

  //////////////////////////////////////////////////
  // pipe port
  //////////////////////////////////////////////////

  word_addr_t wr_word;  // word holding the target halfword
  logic       wr_lane;  // 0 low half, 1 high half
  word_addr_t rd_word;
  logic       rd_lane;

  assign wr_word = mem_wr.addr[HALF_ADDR_W-1:1];
  assign wr_lane = mem_wr.addr[0];
  assign rd_word = rd_half_addr[HALF_ADDR_W-1:1];
  assign rd_lane = rd_half_addr[0];

  // single lane write, other half untouched
  always_ff @(posedge pipe_clk) begin
    if (mem_wr.en) begin
      mem[wr_word].half[wr_lane] <= mem_wr.data;
    end
  end

  // registered halfword read, every cycle
  always_ff @(posedge pipe_clk) begin
    rd_half_data <= mem[rd_word].half[rd_lane];
  end

  //////////////////////////////////////////////////
  // playback port
  //////////////////////////////////////////////////

  // whole word, registered; a same-edge pipe write
  // to this word shows up on the next read only
  always_ff @(posedge pipe_clk) begin
    play_data <= mem[play_addr];
  end

endmodule

/* design/wave_player.sv */
`timescale 1ns/1ps

module wave_player
  import wave_mem_pkg::*, wave_stream_pkg::*;
(
  input  logic                 pipe_clk,
  input  logic                 reset,
  input  logic                 play_en,
  input  logic [WORD_ADDR_W:0] loaded_words,

  // memory playback port
  output word_addr_t           play_addr,
  input  mem_word_u            play_data,

  // wave stream out
  output wave_beat_t           wave,
  output logic                 wave_valid,
  input  logic                 wave_ready
);

  //////////////////////////////////////////////////
  // control state
  //////////////////////////////////////////////////

  logic                 play_en_q;  // for rise detect
  logic [WORD_ADDR_W:0] len_q;      // length latched at play start
  word_addr_t           addr_q;     // next word to issue
  word_addr_t           pend_addr;  // word of the outstanding read
  logic                 rd_pend;    // play_data holds pend_addr's word

  logic                 start;
  logic [WORD_ADDR_W:0] len_cur;
  logic                 out_free;   // output register empty or draining
  logic                 issue;
  logic                 hold;       // pending word stuck behind a full output
  word_addr_t           addr_nxt;

  assign start   = play_en && !play_en_q;
  assign len_cur = start ? loaded_words : len_q;  // latch not visible yet on start

  assign out_free = !wave_valid || wave_ready;
  assign issue    = play_en && (len_cur != '0) && out_free;
  assign hold     = rd_pend && !out_free;

  // last loaded word wraps back to 0
  assign addr_nxt = (({1'b0, addr_q} + 1'b1) >= len_cur) ? '0 : addr_q + 1'b1;

  // stalled: re-read the pending word so play_data keeps it
  assign play_addr = hold ? pend_addr : addr_q;

  //////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge pipe_clk) begin
    if (reset) begin
      play_en_q  <= 1'b0;
      len_q      <= '0;
      addr_q     <= '0;
      pend_addr  <= '0;
      rd_pend    <= 1'b0;
      wave_valid <= 1'b0;
    end else begin
      play_en_q <= play_en;
      if (start) begin
        len_q <= loaded_words;
      end
      if (!play_en) begin
        addr_q <= '0;  // next pass starts at word 0
      end else if (issue) begin
        addr_q <= addr_nxt;
      end
      if (issue) begin
        pend_addr <= addr_q;
        rd_pend   <= 1'b1;
      end else if (out_free) begin
        rd_pend <= 1'b0;  // pending word moved out, or none
      end
      if (out_free) begin
        wave_valid <= rd_pend;  // in-flight word still delivered
      end
    end
  end

  // output payload, only loaded when the slot frees
  always_ff @(posedge pipe_clk) begin
    if (out_free && rd_pend) begin
      wave.wrap <= (pend_addr == '0);
      wave.word <= play_data;
    end
  end

endmodule

/* design/wave_stream_pkg.sv */
package wave_stream_pkg;

  import wave_mem_pkg::*;

  //////////////////////////////////////////////////
  // host pipe side
  //////////////////////////////////////////////////

  // one cycle of host input, wr_stb and rd_stb never together
  typedef struct packed {
    logic        wr_stb;  // store data at pointer, then step
    logic        rd_stb;  // step pointer, data back next cycle
    logic [15:0] data;
  } pipe_cmd_t;

  // loader -> memory halfword write
  typedef struct packed {
    half_addr_t  addr;
    logic [15:0] data;
    logic        en;
  } mem_wr_t;

  //////////////////////////////////////////////////
  // playback side
  //////////////////////////////////////////////////

  typedef struct packed {
    logic      wrap;  // set on word 0 of every pass
    mem_word_u word;
  } wave_beat_t;

endpackage

/* design/waveform_buffer.sv */
`timescale 1ns/1ps

module waveform_buffer
  import wave_mem_pkg::*, wave_stream_pkg::*;
(
  input  logic        pipe_clk,
  input  logic        reset,

  // host pipe
  input  pipe_cmd_t   pipe_in,
  input  logic        pipe_rewind,
  output logic [15:0] pipe_out_data,

  // playback
  input  logic        play_en,
  output wave_beat_t  wave,
  output logic        wave_valid,
  input  logic        wave_ready
);

  //////////////////////////////////////////////////
  // internal wires
  //////////////////////////////////////////////////

  mem_wr_t              mem_wr;        // loader -> memory write
  half_addr_t           rd_half_addr;  // read-back address
  logic [15:0]          rd_half_data;
  logic [WORD_ADDR_W:0] loaded_words;  // high-water length in words
  word_addr_t           play_addr;
  mem_word_u            play_data;

  // input side
  pipe_loader u_loader (
    .pipe_clk      (pipe_clk),
    .reset         (reset),
    .pipe_in       (pipe_in),
    .pipe_rewind   (pipe_rewind),
    .pipe_out_data (pipe_out_data),
    .mem_wr        (mem_wr),
    .rd_half_addr  (rd_half_addr),
    .rd_half_data  (rd_half_data),
    .loaded_words  (loaded_words)
  );

  wave_memory u_memory (
    .pipe_clk     (pipe_clk),
    .mem_wr       (mem_wr),
    .rd_half_addr (rd_half_addr),
    .rd_half_data (rd_half_data),
    .play_addr    (play_addr),
    .play_data    (play_data)
  );

  // output side
  wave_player u_player (
    .pipe_clk     (pipe_clk),
    .reset        (reset),
    .play_en      (play_en),
    .loaded_words (loaded_words),
    .play_addr    (play_addr),
    .play_data    (play_data),
    .wave         (wave),
    .wave_valid   (wave_valid),
    .wave_ready   (wave_ready)
  );

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD       = 40,  // ns
  parameter int RESET_CYCLES = 10
) (
  output logic pipe_clk,
  output logic reset
);

  initial begin
    pipe_clk = 1'b0;
    forever #(PERIOD / 2) pipe_clk = ~pipe_clk;
  end

  // sync reset, released on a rising edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge pipe_clk);
    reset <= 1'b0;
  end

endmodule

/* test/waveform_buffer_asserts.sv */
`timescale 1ns/1ps

module waveform_buffer_asserts
  import wave_stream_pkg::*;
(
  input logic       pipe_clk,
  input logic       reset,
  input pipe_cmd_t  pipe_in,
  input logic       play_en,
  input wave_beat_t wave,
  input logic       wave_valid,
  input logic       wave_ready
);

  logic draining;  // stopped, sink still taking beats
  assign draining = !play_en && wave_ready;

  //////////////////////////////////////////////////
  // host pipe
  //////////////////////////////////////////////////

  a_pipe_excl: assert property (@(posedge pipe_clk) disable iff (reset)
    !(pipe_in.wr_stb && pipe_in.rd_stb))
    else $error("pipe write and read strobes high in the same cycle");

  //////////////////////////////////////////////////
  // wave stream
  //////////////////////////////////////////////////

  // stalled beat must hold still
  a_wave_hold: assert property (@(posedge pipe_clk) disable iff (reset)
    wave_valid && !wave_ready |=> wave_valid && $stable(wave))
    else $error("wave changed or dropped while stalled");

  a_reset_quiet: assert property (@(posedge pipe_clk)
    reset |=> !wave_valid)
    else $error("wave_valid high coming out of reset");

  // at most one read plus one held beat left after play_en drops
  a_stop_drain: assert property (@(posedge pipe_clk) disable iff (reset)
    $past(draining, 2) && $past(draining) |-> !wave_valid)
    else $error("wave_valid still high two cycles after stop");

endmodule

bind waveform_buffer waveform_buffer_asserts u_asserts (.*);

/* test/waveform_buffer_tb.sv */
`timescale 1ns/1ps

module waveform_buffer_tb
  import wave_mem_pkg::*, wave_stream_pkg::*;
();

  localparam int CLK_NS    = 40;
  localparam int BEAT_WAIT = 32;  // idle cycles allowed between beats
  // reset 12, idle 25, readback 70, order 45, backpressure 120, wrap 60, overwrite 35
  localparam int TEST_CYCLES = 367;

  logic        pipe_clk;
  logic        reset;
  pipe_cmd_t   pipe_in;
  logic        pipe_rewind;
  logic [15:0] pipe_out_data;
  logic        play_en;
  wave_beat_t  wave;
  logic        wave_valid;
  logic        wave_ready;

  logic [15:0] lfsr;
  logic [15:0] half_model [DEPTH_WORDS * 2];  // what the memory should hold
  int          model_ptr;
  int          model_len;  // high-water mark in words
  int          n_errors;
  int          n_checks;

  tb_clock_gen #(.PERIOD(CLK_NS), .RESET_CYCLES(10)) clk_i (
    .pipe_clk (pipe_clk),
    .reset    (reset)
  );

  waveform_buffer dut_i (.*);

  //////////////////////////////////////////////////
  // random bits, models, compares
  //////////////////////////////////////////////////

  function automatic logic lfsr_bit();
    logic b;
    b    = lfsr[0];
    lfsr = b ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // galois step with taps 16 14 13 11
    return b;
  endfunction

  function automatic logic [15:0] lfsr_take(input int nbits);
    logic [15:0] bits;
    bits = '0;
    for (int i = 0; i < nbits; i++) begin
      bits = {bits[14:0], lfsr_bit()};
    end
    return bits;
  endfunction

  function automatic logic [15:0] model_half(input int idx);
    return half_model[half_addr_t'(idx)];
  endfunction

  // even halfword -> chan_a, odd -> chan_b
  function automatic wave_beat_t expected_beat(input int idx);
    wave_beat_t b;
    b.wrap             = (idx == 0);
    b.word.chan.chan_a = model_half(2 * idx);
    b.word.chan.chan_b = model_half(2 * idx + 1);
    return b;
  endfunction

  task automatic report_error(input string msg);
    n_errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic check_half(input string name, input logic [15:0] exp, input logic [15:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED %s at %0t: expected %h, got %h", name, $time, exp, act);
    end
  endtask

  task automatic check_beat(input string name, input wave_beat_t exp, input wave_beat_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED %s at %0t: expected %h, got %h", name, $time, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // host pipe and playback drivers
  //////////////////////////////////////////////////

  task automatic rewind_pointer();
    @(posedge pipe_clk);
    pipe_in     <= '0;
    pipe_rewind <= 1'b1;
    @(posedge pipe_clk);
    pipe_rewind <= 1'b0;
    model_ptr = 0;
  endtask

  task automatic load_halves(input int count);
    logic [15:0] data;
    for (int i = 0; i < count; i++) begin
      data = lfsr_take(16);
      @(posedge pipe_clk);
      pipe_in <= '{wr_stb: 1'b1, rd_stb: 1'b0, data: data};
      half_model[half_addr_t'(model_ptr)] = data;
      model_ptr++;
      if ((model_ptr + 1) / 2 > model_len) model_len = (model_ptr + 1) / 2;  // round up
    end
    @(posedge pipe_clk);
    pipe_in <= '0;
  endtask

  // read i lands on the edge after its strobe and is checked at the negedge
  task automatic read_back(input int count);
    for (int i = 0; i <= count; i++) begin
      @(posedge pipe_clk);
      if (i < count) pipe_in <= '{wr_stb: 1'b0, rd_stb: 1'b1, data: 16'h0000};
      else pipe_in <= '0;
      @(negedge pipe_clk);
      if (i > 0) check_half("pipe_out_data", model_half(i - 1), pipe_out_data);
    end
    model_ptr = count;
  endtask

  task automatic play_beats(input int n_beats, input bit random_ready);
    int got;
    int idle;
    int idx;
    got  = 0;
    idle = 0;
    idx  = 0;
    @(posedge pipe_clk);
    play_en    <= 1'b1;
    wave_ready <= random_ready ? lfsr_bit() : 1'b1;
    while (got < n_beats && idle < BEAT_WAIT) begin
      @(negedge pipe_clk);
      if (wave_valid && wave_ready) begin  // transfers on the coming edge
        if (got == 0 && !random_ready && idle != 2)
          report_error($sformatf("first beat came %0d cycles after play_en, not 2", idle));
        if (got > 0 && !random_ready && idle != 0)
          report_error($sformatf("gap of %0d cycles between beats with ready high", idle));
        check_beat("wave", expected_beat(idx), wave);
        idx  = (idx + 1 == model_len) ? 0 : idx + 1;
        got++;
        idle = 0;
      end else begin
        idle++;
      end
      @(posedge pipe_clk);
      wave_ready <= random_ready ? lfsr_bit() : 1'b1;
    end
    if (got < n_beats)
      report_error($sformatf("wave stalled, got %0d of %0d beats", got, n_beats));
    play_en    <= 1'b0;  // in-flight beats drain unchecked
    wave_ready <= 1'b1;
    repeat (3) @(posedge pipe_clk);
    @(negedge pipe_clk);
    if (wave_valid !== 1'b0) report_error("wave_valid still high after play_en dropped");
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic idle_after_reset();
    @(posedge pipe_clk);
    play_en    <= 1'b1;
    wave_ready <= 1'b1;
    repeat (20) begin
      @(negedge pipe_clk);
      n_checks++;
      if (wave_valid !== 1'b0) report_error("wave_valid high with nothing loaded");
    end
    @(posedge pipe_clk);
    play_en <= 1'b0;
    repeat (2) @(posedge pipe_clk);
  endtask

  task automatic load_and_read_back();
    rewind_pointer();
    load_halves(30);  // 15 words that also fill word 14's high half for the wrap test
    rewind_pointer();
    read_back(30);
  endtask

  task automatic play_in_order();
    rewind_pointer();
    load_halves(20);
    play_beats(model_len, 1'b0);
  endtask

  task automatic play_with_stalls();
    play_beats(model_len, 1'b1);  // same words under random stalls
  endtask

  task automatic wrap_odd_count();
    rewind_pointer();
    load_halves(29);  // odd count so the top high half keeps old data
    play_beats(model_len + 3, 1'b0);
  endtask

  task automatic rewind_and_overwrite();
    rewind_pointer();
    load_halves(6);  // length stays at the high-water mark
    play_beats(model_len + 1, 1'b0);
  endtask

  initial begin
    pipe_in     = '0;
    pipe_rewind = 1'b0;
    play_en     = 1'b0;
    wave_ready  = 1'b0;
    lfsr        = 16'd48526;
    model_ptr   = 0;
    model_len   = 0;
    n_errors    = 0;
    n_checks    = 0;
    do @(negedge pipe_clk); while (reset !== 1'b0);
    idle_after_reset();
    load_and_read_back();
    play_in_order();
    play_with_stalls();
    wrap_odd_count();
    rewind_and_overwrite();
    $display("tests done, %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog at twice the summed test length
  initial begin
    #(TEST_CYCLES * 2 * CLK_NS);
    $display("watchdog expired after %0d cycles, tests did not finish", TEST_CYCLES * 2);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* vlog.f */
design/wave_mem_pkg.sv
design/wave_stream_pkg.sv
design/pipe_loader.sv
design/wave_memory.sv
design/wave_player.sv
design/waveform_buffer.sv
test/tb_clock_gen.sv
test/waveform_buffer_asserts.sv
test/waveform_buffer_tb.sv
